// ==== hdl/tti_consts.svh ====
// Width and depth constants shared by the TTI transmit path
// Included by the package, the queue interface and the RTL blocks
`ifndef TTI_CONSTS_SVH
`define TTI_CONSTS_SVH

// CSR and transmit word width
`define TTI_DATA_W 32

// CSR word address width
`define TTI_ADDR_W 3

// Transmit FIFO entries
`define TTI_QUEUE_DEPTH 8

// Level count holds 0 to TTI_QUEUE_DEPTH
`define TTI_LEVEL_W 4

// Ready threshold width
`define TTI_THLD_W 3

`endif

// ==== hdl/tti_csr.sv ====
// TTI register file for the transmit side
// Decodes software accesses, pushes transmit words and holds control and status
`include "tti_consts.svh"

module tti_csr (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    csr_wr_i,
    input  logic                    csr_rd_i,
    input  logic [`TTI_ADDR_W-1:0]  csr_addr_i,
    input  logic [`TTI_DATA_W-1:0]  csr_wdata_i,
    output logic [`TTI_DATA_W-1:0]  csr_rdata_o,

    input  logic                    enec_ibi_i,
    input  logic                    enec_crr_i,
    input  logic                    enec_hj_i,
    input  logic                    disec_ibi_i,
    input  logic                    disec_crr_i,
    input  logic                    disec_hj_i,

    tti_queue_if.producer           q
);
    import tti_pkg::*;

    tti_reg_e               reg_addr;
    logic                   wr_tx;
    logic                   wr_thld;
    logic                   wr_rst;
    logic                   wr_ctrl;
    logic                   rd_status;

    logic [`TTI_THLD_W-1:0] thld_sw_q;
    logic [`TTI_THLD_W-1:0] thld_hw_q;
    logic                   thld_swmod_q;
    logic                   thld_we_q;
    logic                   rst_bit_q;
    logic                   overflow_q;
    logic [2:0]             enable_q;
    logic [2:0]             enable_d;
    logic [2:0]             enec;
    logic [2:0]             disec;
    logic [`TTI_DATA_W-1:0] rdata_d;
    logic [`TTI_DATA_W-1:0] rdata_q;

    assign reg_addr  = tti_reg_e'(csr_addr_i);
    assign wr_tx     = csr_wr_i && (reg_addr == REG_TX_DATA);
    assign wr_thld   = csr_wr_i && (reg_addr == REG_THLD);
    assign wr_rst    = csr_wr_i && (reg_addr == REG_RESET);
    assign wr_ctrl   = csr_wr_i && (reg_addr == REG_CONTROL);
    assign rd_status = csr_rd_i && (reg_addr == REG_STATUS);

    // Words written while the FIFO is full are dropped
    assign q.push      = wr_tx && !q.full;
    assign q.push_data = csr_wdata_i;
    assign q.flush     = rst_bit_q;
    assign q.thld      = thld_hw_q;

    // Bit order is IBI, CRR, HJ from bit 0
    assign enec  = {enec_hj_i, enec_crr_i, enec_ibi_i};
    assign disec = {disec_hj_i, disec_crr_i, disec_ibi_i};

    always_comb begin
        enable_d = enable_q;
        if (wr_ctrl) begin
            enable_d = csr_wdata_i[2:0];
        end
        // ENEC wins over a DISEC in the same cycle
        enable_d = (enable_d & ~disec) | enec;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            thld_sw_q    <= '0;
            thld_hw_q    <= '0;
            thld_swmod_q <= 1'b0;
            thld_we_q    <= 1'b0;
            rst_bit_q    <= 1'b0;
            overflow_q   <= 1'b0;
            enable_q     <= '0;
        end else begin
            if (wr_thld) begin
                thld_sw_q <= csr_wdata_i[`TTI_THLD_W-1:0];
            end
            // Two-stage write enable toward the queue comparison
            thld_swmod_q <= wr_thld;
            thld_we_q    <= thld_swmod_q;
            if (thld_we_q) begin
                thld_hw_q <= thld_sw_q;
            end

            // Reset request stays up until the queue acknowledges it
            if (q.flush_done) begin
                rst_bit_q <= 1'b0;
            end else if (wr_rst && csr_wdata_i[0]) begin
                rst_bit_q <= 1'b1;
            end

            if (wr_tx && q.full) begin
                overflow_q <= 1'b1;
            end else if (rd_status) begin
                overflow_q <= 1'b0;
            end

            enable_q <= enable_d;
        end
    end

    always_comb begin
        rdata_d = '0;
        case (reg_addr)
            REG_THLD:    rdata_d[`TTI_THLD_W-1:0] = thld_sw_q;
            REG_RESET:   rdata_d[0] = rst_bit_q;
            REG_CONTROL: rdata_d[2:0] = enable_q;
            REG_STATUS: begin
                rdata_d[`TTI_LEVEL_W-1:0] = q.level;
                rdata_d[8] = q.thld_hit;
                rdata_d[9] = overflow_q;
            end
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (csr_rd_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign csr_rdata_o = rdata_q;

    // Queue is never pushed while it already holds a full set of words
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        q.push |-> (q.level < `TTI_LEVEL_W'(`TTI_QUEUE_DEPTH)));

    // Queue acknowledges a reset only while it is requested
    a_flush_done_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        q.flush_done |-> q.flush);

endmodule : tti_csr

// ==== hdl/tti_pkg.sv ====
// Types for the TTI transmit path
// Imported inside the module bodies that decode CSRs or run the drain FSM
package tti_pkg;

`include "tti_consts.svh"

    // CSR word addresses
    typedef enum logic [`TTI_ADDR_W-1:0] {
        // Write only, pushes one transmit word
        REG_TX_DATA = 3'd0,
        // Queue ready threshold
        REG_THLD    = 3'd1,
        // Bit 0 requests a queue reset, cleared by hardware
        REG_RESET   = 3'd2,
        // IBI, CRR and HJ enables in bits 0 to 2
        REG_CONTROL = 3'd3,
        // Level, threshold reached and sticky overflow
        REG_STATUS  = 3'd4
    } tti_reg_e;

    // Drain FSM states
    typedef enum logic {
        DRAIN_IDLE = 1'b0,
        DRAIN_SEND = 1'b1
    } drain_state_e;

endpackage : tti_pkg

// ==== hdl/tti_queue_if.sv ====
// Transmit queue connection between the register file, the FIFO and the drain
// Instanced once in the top level and passed to each block through its modport
`include "tti_consts.svh"

interface tti_queue_if;

    logic                    push;
    logic [`TTI_DATA_W-1:0]  push_data;
    logic                    full;
    logic [`TTI_LEVEL_W-1:0] level;
    logic                    thld_hit;
    logic                    flush;
    logic                    flush_done;
    logic [`TTI_THLD_W-1:0]  thld;
    logic                    pop;
    logic [`TTI_DATA_W-1:0]  pop_data;
    logic                    empty;

    modport producer (
        output push, push_data, flush, thld,
        input  full, level, thld_hit, flush_done
    );

    modport buffer (
        input  push, push_data, flush, thld, pop,
        output full, level, thld_hit, flush_done, pop_data, empty
    );

    modport consumer (
        output pop,
        input  pop_data, empty
    );

endinterface : tti_queue_if

// ==== hdl/tti_top.sv ====
// Top level of the TTI transmit path
// Connects register file, transmit FIFO and drain through one queue interface
`include "tti_consts.svh"

module tti_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    input  logic                    csr_wr_i,
    input  logic                    csr_rd_i,
    input  logic [`TTI_ADDR_W-1:0]  csr_addr_i,
    input  logic [`TTI_DATA_W-1:0]  csr_wdata_i,
    output logic [`TTI_DATA_W-1:0]  csr_rdata_o,

    input  logic                    bus_ready_i,

    input  logic                    enec_ibi_i,
    input  logic                    enec_crr_i,
    input  logic                    enec_hj_i,
    input  logic                    disec_ibi_i,
    input  logic                    disec_crr_i,
    input  logic                    disec_hj_i,

    output logic [7:0]              tx_byte_o,
    output logic                    tx_byte_valid_o,
    output logic                    ready_irq_o
);

    tti_queue_if q_if ();

    tti_csr u_csr (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .csr_wr_i    (csr_wr_i),
        .csr_rd_i    (csr_rd_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .enec_ibi_i  (enec_ibi_i),
        .enec_crr_i  (enec_crr_i),
        .enec_hj_i   (enec_hj_i),
        .disec_ibi_i (disec_ibi_i),
        .disec_crr_i (disec_crr_i),
        .disec_hj_i  (disec_hj_i),
        .q           (q_if)
    );

    tti_tx_queue u_tx_queue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .q      (q_if)
    );

    tti_tx_drain u_tx_drain (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .bus_ready_i     (bus_ready_i),
        .tx_byte_o       (tx_byte_o),
        .tx_byte_valid_o (tx_byte_valid_o),
        .q               (q_if)
    );

    assign ready_irq_o = q_if.thld_hit;

endmodule : tti_top

// ==== hdl/tti_tx_drain.sv ====
// Drain FSM that pops transmit words and sends them to the bus side
// One byte per cycle, least significant first, held while bus_ready_i is low
`include "tti_consts.svh"

module tti_tx_drain (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            bus_ready_i,
    output logic [7:0]      tx_byte_o,
    output logic            tx_byte_valid_o,
    tti_queue_if.consumer   q
);
    import tti_pkg::*;

    drain_state_e           state_q;
    logic [`TTI_DATA_W-1:0] word_q;
    logic [1:0]             idx_q;

    assign q.pop           = (state_q == DRAIN_IDLE) && !q.empty;
    assign tx_byte_valid_o = (state_q == DRAIN_SEND) && bus_ready_i;
    assign tx_byte_o       = word_q[idx_q*8 +: 8];

    always_ff @(posedge clk_i) begin
        if (q.pop) begin
            word_q <= q.pop_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DRAIN_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                DRAIN_IDLE: begin
                    if (!q.empty) begin
                        idx_q   <= '0;
                        state_q <= DRAIN_SEND;
                    end
                end
                DRAIN_SEND: begin
                    if (bus_ready_i) begin
                        idx_q <= idx_q + 1'b1;
                        // Last byte of the word
                        if (idx_q == 2'd3) begin
                            state_q <= DRAIN_IDLE;
                        end
                    end
                end
                default: state_q <= DRAIN_IDLE;
            endcase
        end
    end

    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        q.pop |-> !q.empty);

endmodule : tti_tx_drain

// ==== hdl/tti_tx_queue.sv ====
// Transmit data FIFO with level count, ready threshold and flush
// Sits between the register file and the drain through the buffer modport
`include "tti_consts.svh"

module tti_tx_queue (
    input  logic          clk_i,
    input  logic          rst_ni,
    tti_queue_if.buffer   q
);
    localparam int unsigned Depth = `TTI_QUEUE_DEPTH;
    localparam int unsigned PtrW  = $clog2(Depth);

    logic [`TTI_DATA_W-1:0]  mem [Depth];
    logic [PtrW-1:0]         wr_ptr_q;
    logic [PtrW-1:0]         rd_ptr_q;
    logic [`TTI_LEVEL_W-1:0] level_q;
    logic                    flush_done_q;
    logic                    do_push;
    logic                    do_pop;

    assign q.full  = (level_q == `TTI_LEVEL_W'(Depth));
    assign q.empty = (level_q == '0);
    assign do_push = q.push && !q.full;
    assign do_pop  = q.pop && !q.empty;

    assign q.pop_data   = mem[rd_ptr_q];
    assign q.level      = level_q;
    assign q.flush_done = flush_done_q;

    // Zero threshold disables the ready flag
    assign q.thld_hit = (q.thld != '0) && (level_q >= `TTI_LEVEL_W'(q.thld));

    always_ff @(posedge clk_i) begin
        if (do_push && !q.flush) begin
            mem[wr_ptr_q] <= q.push_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            level_q      <= '0;
            flush_done_q <= 1'b0;
        end else begin
            // Single acknowledge pulse per reset request
            flush_done_q <= q.flush && !flush_done_q;
            if (q.flush) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                level_q  <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (do_pop) begin
                    rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                if (do_push && !do_pop) begin
                    level_q <= level_q + 1'b1;
                end else if (do_pop && !do_push) begin
                    level_q <= level_q - 1'b1;
                end
            end
        end
    end

    a_level_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        level_q <= `TTI_LEVEL_W'(Depth));

endmodule : tti_tx_queue

// ==== tests/tti_checker.sv ====
// Monitor for the TTI transmit path testbench
// Compares sent bytes, CSR read data and the ready flag with queued expectations
module tti_checker (
    input logic        clk_i,
    input logic        rst_ni,
    input logic [7:0]  tx_byte_i,
    input logic        tx_byte_valid_i,
    input logic        csr_rd_i,
    input logic [31:0] csr_rdata_i,
    input logic        ready_irq_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  exp_bytes[$];
    logic [31:0] rd_exp[$];
    logic [31:0] rd_mask[$];
    logic        rd_pend;
    logic [7:0]  exp_b;
    logic [31:0] exp_d;
    logic [31:0] mask_d;
    int          byte_errs;
    int          read_errs;
    int          flag_errs;
    int          bytes_seen;

    initial begin
        rd_pend    = 1'b0;
        byte_errs  = 0;
        read_errs  = 0;
        flag_errs  = 0;
        bytes_seen = 0;
    end

    task automatic add_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
    endtask

    task automatic add_read(input logic [31:0] exp, input logic [31:0] mask);
        rd_exp.push_back(exp);
        rd_mask.push_back(mask);
    endtask

    function automatic int pending_bytes();
        return exp_bytes.size();
    endfunction

    function automatic int error_total();
        return byte_errs + read_errs + flag_errs;
    endfunction

    task automatic compare_irq(input logic exp);
        if (ready_irq_i !== exp) begin
            flag_errs++;
            $display("ERROR %0t: ready_irq_o is %b, expected %b", $time, ready_irq_i, exp);
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_ni && tx_byte_valid_i) begin
            bytes_seen++;
            if (exp_bytes.size() == 0) begin
                byte_errs++;
                $display("ERROR %0t: unexpected byte %02h on tx_byte_o", $time, tx_byte_i);
            end else begin
                exp_b = exp_bytes.pop_front();
                if (tx_byte_i !== exp_b) begin
                    byte_errs++;
                    $display("ERROR %0t: tx byte %02h, expected %02h",
                             $time, tx_byte_i, exp_b);
                end
            end
        end
    end

    // Registered read data is valid one edge after the strobe is seen
    always @(posedge clk_i) begin
        if (rd_pend && rd_exp.size() > 0) begin
            exp_d  = rd_exp.pop_front();
            mask_d = rd_mask.pop_front();
            if ((csr_rdata_i & mask_d) !== (exp_d & mask_d)) begin
                read_errs++;
                $display("ERROR %0t: read data %08h, expected %08h under mask %08h",
                         $time, csr_rdata_i, exp_d, mask_d);
            end
        end
        rd_pend = rst_ni && csr_rd_i;
    end

    task automatic report();
        if (exp_bytes.size() != 0) begin
            byte_errs++;
            $display("%0d expected bytes never appeared on tx_byte_o", exp_bytes.size());
        end
        $display("Bytes seen %0d, byte errors %0d, read errors %0d, flag errors %0d",
                 bytes_seen, byte_errs, read_errs, flag_errs);
    endtask

endmodule : tti_checker

// ==== tests/tti_top_tb.sv ====
// Testbench for the TTI transmit path
// Drives CSR writes, ENEC and DISEC pulses and bus back-pressure; tti_checker compares
`include "tti_consts.svh"

module tti_top_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tti_pkg::*;

    typedef logic [7:0] byte_q_t[$];
    typedef logic [`TTI_DATA_W-1:0] word_q_t[$];

    localparam int MaxCycles = 4000;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   csr_wr_i;
    logic                   csr_rd_i;
    logic [`TTI_ADDR_W-1:0] csr_addr_i;
    logic [`TTI_DATA_W-1:0] csr_wdata_i;
    logic [`TTI_DATA_W-1:0] csr_rdata_o;
    logic                   bus_ready_i;
    logic                   enec_ibi_i;
    logic                   enec_crr_i;
    logic                   enec_hj_i;
    logic                   disec_ibi_i;
    logic                   disec_crr_i;
    logic                   disec_hj_i;
    logic [7:0]             tx_byte_o;
    logic                   tx_byte_valid_o;
    logic                   ready_irq_o;

    int                     cycle_cnt;
    logic                   toggle_ready;
    logic [`TTI_DATA_W-1:0] data;
    logic [2:0]             en_m;
    logic [2:0]             e;
    logic [2:0]             d;
    int                     thld_m;
    int                     lvl;
    logic                   hit;

    tti_top tti_top_i (.*);

    tti_checker chk (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .tx_byte_i       (tx_byte_o),
        .tx_byte_valid_i (tx_byte_valid_o),
        .csr_rd_i        (csr_rd_i),
        .csr_rdata_i     (csr_rdata_o),
        .ready_irq_i     (ready_irq_o)
    );

    // Words leave the drain least significant byte first
    function automatic byte_q_t tti_expect_bytes(input word_q_t words);
        byte_q_t bytes;
        foreach (words[i]) begin
            for (int b = 0; b < 4; b++) begin
                bytes.push_back(words[i][8*b +: 8]);
            end
        end
        return bytes;
    endfunction

    // Enable bits after one cycle of ENEC and DISEC pulses
    function automatic logic [2:0] next_enables(input logic [2:0] cur,
                                                input logic [2:0] set_bits,
                                                input logic [2:0] clr_bits);
        logic [2:0] nxt;
        nxt = cur;
        for (int i = 0; i < 3; i++) begin
            if (set_bits[i]) begin
                nxt[i] = 1'b1;
            end else if (clr_bits[i]) begin
                nxt[i] = 1'b0;
            end
        end
        return nxt;
    endfunction

    task automatic csr_write(input tti_reg_e addr, input logic [`TTI_DATA_W-1:0] wdata);
        @(posedge clk_i);
        csr_wr_i    <= 1'b1;
        csr_addr_i  <= addr;
        csr_wdata_i <= wdata;
        @(posedge clk_i);
        csr_wr_i <= 1'b0;
    endtask

    // Read data is registered, so it is sampled two edges after the strobe
    task automatic csr_read(input tti_reg_e addr, input logic [`TTI_DATA_W-1:0] exp,
                            input logic [`TTI_DATA_W-1:0] mask,
                            output logic [`TTI_DATA_W-1:0] rdata);
        @(posedge clk_i);
        chk.add_read(exp, mask);
        csr_rd_i   <= 1'b1;
        csr_addr_i <= addr;
        @(posedge clk_i);
        csr_rd_i <= 1'b0;
        @(posedge clk_i);
        rdata = csr_rdata_o;
    endtask

    task automatic send_words(input int n);
        word_q_t words;
        byte_q_t bytes;
        for (int i = 0; i < n; i++) begin
            words.push_back($urandom);
        end
        bytes = tti_expect_bytes(words);
        foreach (bytes[i]) begin
            chk.add_byte(bytes[i]);
        end
        foreach (words[i]) begin
            csr_write(REG_TX_DATA, words[i]);
        end
    endtask

    task automatic wait_drained();
        while (chk.pending_bytes() > 0) begin
            @(posedge clk_i);
        end
        repeat (10) @(posedge clk_i);
    endtask

    task automatic pulse_events(input logic [2:0] set_bits, input logic [2:0] clr_bits);
        @(posedge clk_i);
        {enec_hj_i, enec_crr_i, enec_ibi_i}    <= set_bits;
        {disec_hj_i, disec_crr_i, disec_ibi_i} <= clr_bits;
        @(posedge clk_i);
        {enec_hj_i, enec_crr_i, enec_ibi_i}    <= 3'b000;
        {disec_hj_i, disec_crr_i, disec_ibi_i} <= 3'b000;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (toggle_ready) begin
            bus_ready_i <= 1'($urandom_range(0, 1));
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MaxCycles) begin
            $display("Run did not finish within %0d cycles", MaxCycles);
            chk.report();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(78308));
        cycle_cnt    = 0;
        toggle_ready = 1'b0;
        rst_ni       = 1'b0;
        csr_wr_i     = 1'b0;
        csr_rd_i     = 1'b0;
        csr_addr_i   = '0;
        csr_wdata_i  = '0;
        bus_ready_i  = 1'b1;
        {enec_hj_i, enec_crr_i, enec_ibi_i}    = 3'b000;
        {disec_hj_i, disec_crr_i, disec_ibi_i} = 3'b000;
        en_m   = 3'b000;
        thld_m = 0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Streaming with the bus always ready
        repeat (3) begin
            send_words(8);
            wait_drained();
        end

        // Fill the drain and the FIFO, then overflow
        @(posedge clk_i);
        bus_ready_i <= 1'b0;
        send_words(9);
        csr_read(REG_STATUS, 32'h008, 32'h30f, data);
        csr_write(REG_TX_DATA, $urandom);
        csr_read(REG_STATUS, 32'h208, 32'h30f, data);
        csr_read(REG_STATUS, 32'h008, 32'h30f, data);
        @(posedge clk_i);
        bus_ready_i <= 1'b1;
        wait_drained();

        // Ready threshold as the FIFO grows
        csr_write(REG_THLD, 3);
        thld_m = 3;
        repeat (3) @(posedge clk_i);
        bus_ready_i <= 1'b0;
        for (int n = 1; n <= 5; n++) begin
            send_words(1);
            repeat (2) @(posedge clk_i);
            // First word sits in the drain
            lvl = n - 1;
            hit = (thld_m != 0) && (lvl >= thld_m);
            chk.compare_irq(hit);
            csr_read(REG_STATUS, lvl | (32'(hit) << 8), 32'h10f, data);
        end
        @(posedge clk_i);
        bus_ready_i <= 1'b1;
        wait_drained();

        // Queue reset drops everything behind the drain
        @(posedge clk_i);
        bus_ready_i <= 1'b0;
        send_words(1);
        repeat (2) @(posedge clk_i);
        repeat (3) csr_write(REG_TX_DATA, $urandom);
        csr_read(REG_STATUS, 32'h3, 32'hf, data);
        csr_write(REG_RESET, 32'h1);
        // Request is still visible on the first poll
        csr_read(REG_RESET, 32'h1, 32'h1, data);
        while (data[0]) begin
            csr_read(REG_RESET, 32'h0, 32'h1, data);
        end
        csr_read(REG_STATUS, 32'h0, 32'hf, data);
        @(posedge clk_i);
        bus_ready_i <= 1'b1;
        wait_drained();
        repeat (30) @(posedge clk_i);

        // ENEC and DISEC, both at once first
        pulse_events(3'b111, 3'b000);
        en_m = 3'b111;
        csr_read(REG_CONTROL, en_m, 32'h7, data);
        pulse_events(3'b101, 3'b111);
        en_m = next_enables(en_m, 3'b101, 3'b111);
        csr_read(REG_CONTROL, en_m, 32'h7, data);
        repeat (12) begin
            e = 3'($urandom_range(0, 7));
            d = 3'($urandom_range(0, 7));
            pulse_events(e, d);
            en_m = next_enables(en_m, e, d);
            csr_read(REG_CONTROL, en_m, 32'h7, data);
        end

        // Random back-pressure
        toggle_ready <= 1'b1;
        repeat (3) begin
            send_words(8);
            wait_drained();
        end
        toggle_ready <= 1'b0;
        @(posedge clk_i);
        bus_ready_i <= 1'b1;
        repeat (10) @(posedge clk_i);

        chk.report();
        if (chk.error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tti_top_tb

// ==== tti_top.f ====
+incdir+hdl
hdl/tti_pkg.sv
hdl/tti_queue_if.sv
hdl/tti_csr.sv
hdl/tti_tx_queue.sv
hdl/tti_tx_drain.sv
hdl/tti_top.sv
tests/tti_checker.sv
tests/tti_top_tb.sv
